// File: common/cae_pkg.sv
// coprocessor dispatch definitions

package cae_pkg;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int CAE_INST_W = 32;
   localparam int CAE_DATA_W = 64;
   localparam int CAE_EXC_W  = 16;
   localparam int AEG_IDX_W  = 18;
   localparam int CAEP_W     = 5;

   // highest caep that opens a busy window
   localparam logic [CAEP_W-1:0] CAEP_LAST = 5'd5;

   // exception vector bit positions
   localparam int EXC_UNIMPL_BIT = 0;
   localparam int EXC_AEGIDX_BIT = 1;

   // ------------------------------
   // instruction fields
   // ------------------------------
   localparam int CAE_OP_MSB = 31;
   localparam int CAE_OP_LSB = 30;
   localparam int CAEP_MSB   = 29;
   localparam int CAEP_LSB   = 25;
   // index sits in the low AEG_IDX_W bits

   typedef enum logic [1:0] {
      OP_NONE   = 2'd0,
      OP_AEG_WR = 2'd1,
      OP_AEG_RD = 2'd2,
      OP_CAEP   = 2'd3
   } cae_op_e;

   typedef logic [CAE_DATA_W-1:0] aeg_word_t;

   // one accepted instruction, already classified
   typedef struct packed {
      logic                 aeg_wr;
      logic                 aeg_rd;
      logic                 err_aegidx;
      logic                 err_unimpl;
      logic                 custom_start;
      logic [AEG_IDX_W-1:0] aeg_idx;
      aeg_word_t            wr_data;
   } dispatch_t;

endpackage

// File: design/cae_inst_decoder.sv
// dispatch instruction decoder

module cae_inst_decoder #(
   parameter int NUM_AEG = 51
) (
   input  logic [cae_pkg::CAE_INST_W-1:0] cae_inst_i,
   input  cae_pkg::aeg_word_t             cae_data_i,
   input  logic                           cae_inst_vld_i,
   input  logic                           busy_i,
   output cae_pkg::dispatch_t             dispatch_o
);

   import cae_pkg::*;

   localparam logic [AEG_IDX_W-1:0] IDX_LIMIT = AEG_IDX_W'(NUM_AEG);

   logic                 accept;
   cae_op_e              op;
   logic [CAEP_W-1:0]    caep;
   logic [AEG_IDX_W-1:0] idx;
   logic                 idx_ok;

   // ------------------------------
   // field split
   // ------------------------------

   // strobes during a busy window are dropped here
   assign accept = cae_inst_vld_i & ~busy_i;

   assign op     = cae_op_e'(cae_inst_i[CAE_OP_MSB:CAE_OP_LSB]);
   assign caep   = cae_inst_i[CAEP_MSB:CAEP_LSB];
   assign idx    = cae_inst_i[AEG_IDX_W-1:0];

   // full index width compared, upper bits count too
   assign idx_ok = idx < IDX_LIMIT;

   // ------------------------------
   // classify
   // ------------------------------
   always_comb begin
      dispatch_o         = '0;
      dispatch_o.aeg_idx = idx;
      dispatch_o.wr_data = cae_data_i;

      if (accept) begin
         case (op)
            OP_AEG_WR: begin
               dispatch_o.aeg_wr     = idx_ok;
               dispatch_o.err_aegidx = ~idx_ok;
            end
            OP_AEG_RD: begin
               dispatch_o.aeg_rd     = idx_ok;
               dispatch_o.err_aegidx = ~idx_ok;
            end
            OP_CAEP: begin
               // caep 0..CAEP_LAST only open the busy window
               if (caep <= CAEP_LAST) begin
                  dispatch_o.custom_start = 1'b1;
               end else begin
                  dispatch_o.err_unimpl = 1'b1;
               end
            end
            default: begin
               dispatch_o.err_unimpl = 1'b1;
            end
         endcase
      end
   end

endmodule

// File: aeg/aeg_reg_file.sv
// application engine register file

module aeg_reg_file #(
   parameter int NUM_AEG = 51
) (
   input  logic               clk_per,
   input  logic               rst_n_i,
   input  cae_pkg::dispatch_t dispatch_i,
   output cae_pkg::aeg_word_t rd_data_o
);

   import cae_pkg::*;

   localparam int ADDR_W = $clog2(NUM_AEG);

   aeg_word_t         aeg_mem [NUM_AEG];
   logic [ADDR_W-1:0] addr;

   // low bits select the word
   assign addr = dispatch_i.aeg_idx[ADDR_W-1:0];

   // ------------------------------
   // write port
   // ------------------------------

   // registers read zero after reset, host software relies on it
   always_ff @(posedge clk_per) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NUM_AEG; i++) begin
            aeg_mem[i] <= '0;
         end
      end else if (dispatch_i.aeg_wr) begin
         // decoder only flags writes with a valid index
         aeg_mem[addr] <= dispatch_i.wr_data;
      end
   end

   // ------------------------------
   // read port
   // ------------------------------

   // combinational, response stage does the registering
   assign rd_data_o = aeg_mem[addr];

endmodule

// File: design/custom_busy_timer.sv
// custom instruction busy window

module custom_busy_timer #(
   parameter int BUSY_CYCLES = 4
) (
   input  logic clk_per,
   input  logic rst_n_i,
   input  logic start_i,
   output logic busy_o,
   output logic cae_stall_o,
   output logic cae_idle_o
);

   localparam int CNT_W = $clog2(BUSY_CYCLES + 1);

   logic [CNT_W-1:0] busy_cnt;

   // ------------------------------
   // down-counter
   // ------------------------------

   // loaded in the accept cycle, so stall covers
   // the accept cycle plus BUSY_CYCLES more
   always_ff @(posedge clk_per) begin
      if (!rst_n_i) begin
         busy_cnt <= '0;
      end else if (start_i) begin
         busy_cnt <= CNT_W'(BUSY_CYCLES);
      end else if (busy_cnt != '0) begin
         busy_cnt <= busy_cnt - 1'b1;
      end
   end

   // ------------------------------
   // host status
   // ------------------------------

   // feeds back to the decoder to block new instructions
   assign busy_o = busy_cnt != '0;

   // start_i is used directly so stall rises in the accept cycle
   assign cae_stall_o = start_i | busy_o;

   // idle is simply the inverse of stall
   assign cae_idle_o  = ~cae_stall_o;

endmodule

// File: design/cae_response.sv
// dispatch return and exception stage

module cae_response (
   input  logic                          clk_per,
   input  logic                          rst_n_i,
   input  cae_pkg::dispatch_t            dispatch_i,
   input  cae_pkg::aeg_word_t            rd_data_i,
   output cae_pkg::aeg_word_t            cae_ret_data_o,
   output logic                          cae_ret_data_vld_o,
   output logic [cae_pkg::CAE_EXC_W-1:0] cae_exception_o
);

   import cae_pkg::*;

   aeg_word_t            ret_data_q;
   logic                 ret_vld_q;
   logic [CAE_EXC_W-1:0] exc_q;

   // ------------------------------
   // control flops
   // ------------------------------

   // valid and exceptions last exactly one cycle
   always_ff @(posedge clk_per) begin
      if (!rst_n_i) begin
         ret_vld_q <= 1'b0;
         exc_q     <= '0;
      end else begin
         ret_vld_q                 <= dispatch_i.aeg_rd;
         exc_q                     <= '0;
         exc_q[EXC_UNIMPL_BIT]     <= dispatch_i.err_unimpl;
         exc_q[EXC_AEGIDX_BIT]     <= dispatch_i.err_aegidx;
      end
   end

   // ------------------------------
   // return data
   // ------------------------------

   // holds last read word between reads
   always_ff @(posedge clk_per) begin
      if (dispatch_i.aeg_rd) begin
         ret_data_q <= rd_data_i;
      end
   end

   assign cae_ret_data_o     = ret_data_q;
   assign cae_ret_data_vld_o = ret_vld_q;
   assign cae_exception_o    = exc_q;

endmodule

// File: design/cae_pers_top.sv
// coprocessor personality dispatch top

module cae_pers_top #(
   parameter int NUM_AEG     = 51,
   parameter int BUSY_CYCLES = 4
) (
   input  logic                          clk_per,
   input  logic                          rst_n_i,

   // host dispatch
   input  logic [cae_pkg::CAE_INST_W-1:0] cae_inst_i,
   input  cae_pkg::aeg_word_t             cae_data_i,
   input  logic                           cae_inst_vld_i,

   // return and status
   output cae_pkg::aeg_word_t             cae_ret_data_o,
   output logic                           cae_ret_data_vld_o,
   output logic [cae_pkg::CAE_EXC_W-1:0]  cae_exception_o,
   output logic                           cae_stall_o,
   output logic                           cae_idle_o
);

   import cae_pkg::*;

   dispatch_t dispatch;
   aeg_word_t rd_data;
   logic      busy;

   // ------------------------------
   // decode
   // ------------------------------
   cae_inst_decoder #(
      .NUM_AEG (NUM_AEG)
   ) cae_inst_decoder_inst (
      .cae_inst_i     (cae_inst_i),
      .cae_data_i     (cae_data_i),
      .cae_inst_vld_i (cae_inst_vld_i),
      .busy_i         (busy),
      .dispatch_o     (dispatch)
   );

   // ------------------------------
   // registers and busy window
   // ------------------------------
   aeg_reg_file #(
      .NUM_AEG (NUM_AEG)
   ) aeg_reg_file_inst (
      .clk_per    (clk_per),
      .rst_n_i    (rst_n_i),
      .dispatch_i (dispatch),
      .rd_data_o  (rd_data)
   );

   // custom instructions do no work, they only stall the host
   custom_busy_timer #(
      .BUSY_CYCLES (BUSY_CYCLES)
   ) custom_busy_timer_inst (
      .clk_per     (clk_per),
      .rst_n_i     (rst_n_i),
      .start_i     (dispatch.custom_start),
      .busy_o      (busy),
      .cae_stall_o (cae_stall_o),
      .cae_idle_o  (cae_idle_o)
   );

   // ------------------------------
   // response
   // ------------------------------
   cae_response cae_response_inst (
      .clk_per            (clk_per),
      .rst_n_i            (rst_n_i),
      .dispatch_i         (dispatch),
      .rd_data_i          (rd_data),
      .cae_ret_data_o     (cae_ret_data_o),
      .cae_ret_data_vld_o (cae_ret_data_vld_o),
      .cae_exception_o    (cae_exception_o)
   );

endmodule

// File: tests/cae_pers_props.sv
// dispatch handshake properties

module cae_pers_props #(
   parameter int NUM_AEG     = 51,
   parameter int BUSY_CYCLES = 4
) (
   input logic                           clk_per,
   input logic                           rst_n_i,
   input logic [cae_pkg::CAE_INST_W-1:0] inst_i,
   input logic                           inst_vld_i,
   input logic                           busy_i,
   input logic                           ret_vld_i,
   input logic                           stall_i,
   input logic                           idle_i
);

   timeunit 1ns;
   timeprecision 1ps;

   import cae_pkg::*;

   logic rd_accept;
   logic new_start;
   int   stall_run;

   // read seen from the host side of the decoder
   assign rd_accept = inst_vld_i & ~busy_i &
                      (cae_op_e'(inst_i[CAE_OP_MSB:CAE_OP_LSB]) == OP_AEG_RD) &
                      (inst_i[AEG_IDX_W-1:0] < AEG_IDX_W'(NUM_AEG));

   // stall with an empty counter marks a fresh window
   assign new_start = stall_i & ~busy_i;

   always_ff @(posedge clk_per) begin
      if (!rst_n_i) begin
         stall_run <= 0;
      end else if (new_start) begin
         stall_run <= 1;
      end else if (stall_i) begin
         stall_run <= stall_run + 1;
      end else begin
         stall_run <= 0;
      end
   end

   // ------------------------------
   // properties
   // ------------------------------
   idle_inverse: assert property (@(posedge clk_per) disable iff (!rst_n_i)
      idle_i == !stall_i)
      else $error("idle is not the inverse of stall");

   ret_after_read: assert property (@(posedge clk_per) disable iff (!rst_n_i)
      ret_vld_i |-> $past(rd_accept))
      else $error("return valid without an accepted read one cycle earlier");

   stall_bounded: assert property (@(posedge clk_per) disable iff (!rst_n_i)
      stall_run <= BUSY_CYCLES + 1)
      else $error("stall window longer than the busy length");

endmodule

bind cae_pers_top cae_pers_props #(
   .NUM_AEG     (NUM_AEG),
   .BUSY_CYCLES (BUSY_CYCLES)
) cae_pers_props_inst (
   .clk_per    (clk_per),
   .rst_n_i    (rst_n_i),
   .inst_i     (cae_inst_i),
   .inst_vld_i (cae_inst_vld_i),
   .busy_i     (busy),
   .ret_vld_i  (cae_ret_data_vld_o),
   .stall_i    (cae_stall_o),
   .idle_i     (cae_idle_o)
);

// File: tests/cae_pers_tb.sv
// dispatch personality testbench

module cae_pers_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_AEG       = 51;
   localparam int BUSY_CYCLES   = 4;
   localparam int CAEP_LAST     = 5;
   localparam int CLK_PERIOD    = 100;
   localparam int DRIVE_DLY     = 10;
   localparam int CHECK_DLY     = 50;
   localparam int RESET_CYCLES  = 8;
   localparam int RANDOM_CYCLES = 2000;
   localparam int TOTAL_CYCLES  = RESET_CYCLES + 2 * NUM_AEG + BUSY_CYCLES + RANDOM_CYCLES + 4;
   localparam int WATCHDOG_NS   = CLK_PERIOD * TOTAL_CYCLES * 3 / 2;

   logic        clk_per;
   logic        rst_n;
   logic [31:0] cae_inst;
   logic [63:0] cae_data;
   logic        cae_inst_vld;
   logic [63:0] ret_data;
   logic        ret_vld;
   logic [15:0] exception;
   logic        stall;
   logic        idle;

   // reference model state
   logic [63:0] model_mem [NUM_AEG];
   int          model_cnt;
   logic        exp_vld;
   logic [63:0] exp_data;
   logic [15:0] exp_exc;
   logic [31:0] lcg_state;

   int check_count;
   int error_count;
   int read_count;
   int custom_count;
   int ignored_count;
   int idx_err_count;

   cae_pers_top cae_pers_top_inst (
      .clk_per            (clk_per),
      .rst_n_i            (rst_n),
      .cae_inst_i         (cae_inst),
      .cae_data_i         (cae_data),
      .cae_inst_vld_i     (cae_inst_vld),
      .cae_ret_data_o     (ret_data),
      .cae_ret_data_vld_o (ret_vld),
      .cae_exception_o    (exception),
      .cae_stall_o        (stall),
      .cae_idle_o         (idle)
   );

   initial begin
      clk_per = 1'b0;
      forever #(CLK_PERIOD / 2) clk_per = ~clk_per;
   end

   // ------------------------------
   // helpers
   // ------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // op in 31:30, caep in 29:25, index in 17:0
   function automatic logic [31:0] make_inst(input logic [1:0] op, input logic [2:0] caep,
                                             input logic [5:0] idx);
      logic [31:0] inst;
      inst        = '0;
      inst[31:30] = op;
      inst[27:25] = caep;
      inst[5:0]   = idx;
      return inst;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      check_count++;
      assert (got === exp) else begin
         error_count++;
         $display("[ERROR] %0t ns %s: expected 'h%0h, got 'h%0h", $time, name, exp, got);
      end
   endtask

   // one clock cycle: drive, check, then advance the model past the edge
   task automatic run_cycle(input logic vld, input logic [1:0] op, input logic [2:0] caep,
                            input logic [5:0] idx, input logic [63:0] data);
      logic accept;
      logic start_now;
      logic stall_exp;

      @(posedge clk_per);
      #DRIVE_DLY;
      cae_inst_vld = vld;
      cae_inst     = make_inst(op, caep, idx);
      cae_data     = data;

      accept    = vld && (model_cnt == 0);
      start_now = accept && (op == 2'd3) && (caep <= CAEP_LAST);
      stall_exp = start_now || (model_cnt != 0);

      #CHECK_DLY;
      check_value("cae_stall_o", 64'(stall), 64'(stall_exp));
      check_value("cae_idle_o", 64'(idle), 64'(!stall_exp));
      check_value("cae_ret_data_vld_o", 64'(ret_vld), 64'(exp_vld));
      if (exp_vld) begin
         check_value("cae_ret_data_o", ret_data, exp_data);
         read_count++;
      end
      check_value("cae_exception_o", 64'(exception), 64'(exp_exc));

      // outputs due in the next cycle
      exp_vld = 1'b0;
      exp_exc = '0;
      if (accept) begin
         case (op)
            2'd1: begin
               if (idx < NUM_AEG) begin
                  model_mem[idx] = data;
               end else begin
                  exp_exc[1] = 1'b1;
                  idx_err_count++;
               end
            end
            2'd2: begin
               if (idx < NUM_AEG) begin
                  exp_vld  = 1'b1;
                  exp_data = model_mem[idx];
               end else begin
                  exp_exc[1] = 1'b1;
                  idx_err_count++;
               end
            end
            2'd3: begin
               if (caep > CAEP_LAST) begin
                  exp_exc[0] = 1'b1;
               end
            end
            default: begin
               exp_exc[0] = 1'b1;
            end
         endcase
      end else if (vld) begin
         ignored_count++;
      end

      if (start_now) begin
         model_cnt = BUSY_CYCLES;
         custom_count++;
      end else if (model_cnt != 0) begin
         model_cnt--;
      end
   endtask

   // strobe rarely inside a busy window, often outside it
   task automatic random_cycle();
      logic [31:0] r;
      logic        vld;
      logic [1:0]  op;
      logic [63:0] data;

      r = lcg_next();
      if (model_cnt != 0) begin
         vld = (r[3:0] == 4'd0);
      end else begin
         vld = (r[1:0] != 2'd0);
      end
      case (r[7:5])
         3'd0:                op = 2'd0;
         3'd1, 3'd2, 3'd3:    op = 2'd1;
         3'd4, 3'd5, 3'd6:    op = 2'd2;
         default:             op = 2'd3;
      endcase
      data = {lcg_next(), lcg_next()};
      run_cycle(vld, op, r[10:8], r[16:11], data);
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      cae_inst      = '0;
      cae_data      = '0;
      cae_inst_vld  = 1'b0;
      rst_n         = 1'b0;
      lcg_state     = 32'hc4a3_32ce;
      model_cnt     = 0;
      exp_vld       = 1'b0;
      exp_data      = '0;
      exp_exc       = '0;
      check_count   = 0;
      error_count   = 0;
      read_count    = 0;
      custom_count  = 0;
      ignored_count = 0;
      idx_err_count = 0;
      for (int i = 0; i < NUM_AEG; i++) begin
         model_mem[i] = '0;
      end

      repeat (RESET_CYCLES) @(posedge clk_per);
      #DRIVE_DLY;
      rst_n = 1'b1;

      // every register reads zero out of reset
      for (int i = 0; i < NUM_AEG; i++) begin
         run_cycle(1'b1, 2'd2, 3'd0, 6'(i), '0);
      end

      for (int n = 0; n < RANDOM_CYCLES; n++) begin
         random_cycle();
      end

      // let any window close, then sweep all registers
      for (int n = 0; n <= BUSY_CYCLES; n++) begin
         run_cycle(1'b0, 2'd0, 3'd0, 6'd0, '0);
      end
      for (int i = 0; i < NUM_AEG; i++) begin
         run_cycle(1'b1, 2'd2, 3'd0, 6'(i), '0);
      end
      run_cycle(1'b0, 2'd0, 3'd0, 6'd0, '0);

      assert (custom_count > 0) else begin
         error_count++;
         $display("no custom instruction was accepted during the run");
      end
      assert (ignored_count > 0) else begin
         error_count++;
         $display("no strobe arrived during a stall window");
      end
      assert (idx_err_count > 0) else begin
         error_count++;
         $display("no out-of-range index was accepted during the run");
      end

      $display("checks %0d, errors %0d, reads %0d, custom %0d, ignored %0d, index errors %0d",
               check_count, error_count, read_count, custom_count, ignored_count,
               idx_err_count);
      if (error_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #WATCHDOG_NS;
      $display("simulation ran past its time limit without completing the tests");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: verilog.f
common/cae_pkg.sv
design/cae_inst_decoder.sv
aeg/aeg_reg_file.sv
design/custom_busy_timer.sv
design/cae_response.sv
design/cae_pers_top.sv
tests/cae_pers_props.sv
tests/cae_pers_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the dispatch testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=cae_pers_sim

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module cae_pers_tb -f verilog.f -o "$BIN"
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"
exit 0
